// File: source/cpu_pkg.sv
package cpu_pkg;

    // Memory sizes in 32-bit words
    localparam int ROM_WORDS = 256;
    localparam int RAM_WORDS = 256;

    // Memory map
    localparam logic [31:0] ROM_BASE = 32'h0000_0000;
    localparam logic [31:0] RAM_BASE = 32'h0000_1000;
    localparam logic [31:0] LED_ADDR = 32'h0000_2000;
    localparam logic [31:0] SW_ADDR  = 32'h0000_2004;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        FETCH_DECODE,
        REG_READ,
        EXECUTE,
        MEM_ACCESS,
        WRITE_BACK
    } cpu_state_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B, PC_ADD
    } alu_op_t;

    typedef enum logic [2:0] {
        NONE, EQ, NE, LT, GE, LTU, GEU, ALWAYS
    } branch_op_t;

    typedef enum logic [1:0] {
        BYTE, HALF, WORD
    } mem_size_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        rd_en;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        is_load;
        logic        is_store;
        mem_size_t   mem_size;
        logic        mem_unsigned;
        branch_op_t  branch_op;
        logic        is_jalr;
        logic        is_link;
    } decoded_instr_t;

endpackage

// File: source/decode.sv
`timescale 1ns/1ns

module decode import cpu_pkg::*; (
    input  logic [31:0]    instr,
    output decoded_instr_t dec
);

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // SUB only exists in register form, SRA in both
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic f7b5,
                                         input logic reg_form);
        case (f3)
            3'd0:    return (reg_form && f7b5) ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return f7b5 ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    always_comb begin
        dec              = '0;
        dec.rs1          = instr[19:15];
        dec.rs2          = instr[24:20];
        dec.rd           = instr[11:7];
        dec.alu_op       = ADD;
        dec.branch_op    = NONE;
        dec.mem_size     = funct3[1] ? WORD : (funct3[0] ? HALF : BYTE);
        dec.mem_unsigned = funct3[2];
        case (opcode)
            OP_LUI: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.alu_op  = PASS_B;
            end
            OP_AUIPC: begin
                dec.rd_en  = 1'b1;
                dec.imm    = imm_u;
                dec.alu_op = PC_ADD;
            end
            OP_JAL: begin
                dec.rd_en     = 1'b1;
                dec.imm       = imm_j;
                dec.alu_op    = PC_ADD;
                dec.branch_op = ALWAYS;
                dec.is_link   = 1'b1;
            end
            OP_JALR: begin
                dec.rd_en     = 1'b1;
                dec.imm       = imm_i;
                dec.alu_op    = PC_ADD;
                dec.branch_op = ALWAYS;
                dec.is_jalr   = 1'b1;
                dec.is_link   = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    3'd0:    dec.branch_op = EQ;
                    3'd1:    dec.branch_op = NE;
                    3'd4:    dec.branch_op = LT;
                    3'd5:    dec.branch_op = GE;
                    3'd6:    dec.branch_op = LTU;
                    3'd7:    dec.branch_op = GEU;
                    default: dec.branch_op = NONE;
                endcase
            end
            OP_LOAD: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_i;
                dec.is_load = 1'b1;
            end
            OP_STORE: begin
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            OP_IMM: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.alu_op  = arith_op(funct3, instr[30], 1'b0);
            end
            OP_REG: begin
                dec.rd_en  = 1'b1;
                dec.alu_op = arith_op(funct3, instr[30], 1'b1);
            end
            default: begin
                dec.rd_en = 1'b0;
            end
        endcase
    end

endmodule

// File: source/rf.sv
`timescale 1ns/1ns

module rf import cpu_pkg::*; (
    input  logic           CLK100MHZ,
    input  logic           rst_n,
    input  cpu_state_t     state,
    input  decoded_instr_t dec,
    input  logic [31:0]    result,
    input  logic [31:0]    load_data,
    output logic [31:0]    rs1_val,
    output logic [31:0]    rs2_val
);

    logic [31:0] regs [32];
    logic [31:0] wb_val;

    assign wb_val = dec.is_load ? load_data : result;

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (state == WRITE_BACK && dec.rd_en && dec.rd != 5'd0) begin
            regs[dec.rd] <= wb_val;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (state == REG_READ) begin
            rs1_val <= regs[dec.rs1];
            rs2_val <= regs[dec.rs2];
        end
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  logic           CLK100MHZ,
    input  logic           rst_n,
    input  cpu_state_t     state,
    input  decoded_instr_t dec,
    input  logic [31:0]    pc,
    input  logic [31:0]    rs1_val,
    input  logic [31:0]    rs2_val,
    output logic [31:0]    result,
    output logic [31:0]    address,
    output logic           taken
);

    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] addr_base;
    logic [31:0] target;
    logic        cond;

    assign op_b = dec.use_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.alu_op)
            ADD:     alu_out = rs1_val + op_b;
            SUB:     alu_out = rs1_val - op_b;
            SLL:     alu_out = rs1_val << op_b[4:0];
            SLT:     alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
            SLTU:    alu_out = {31'b0, rs1_val < op_b};
            XOR:     alu_out = rs1_val ^ op_b;
            SRL:     alu_out = rs1_val >> op_b[4:0];
            SRA:     alu_out = $signed(rs1_val) >>> op_b[4:0];
            OR:      alu_out = rs1_val | op_b;
            AND:     alu_out = rs1_val & op_b;
            PASS_B:  alu_out = op_b;
            default: alu_out = pc + dec.imm;
        endcase
    end

    // Register-relative for memory and JALR, PC-relative otherwise
    assign addr_base = (dec.is_load || dec.is_store || dec.is_jalr) ? rs1_val : pc;
    assign target    = addr_base + dec.imm;

    always_comb begin
        case (dec.branch_op)
            EQ:      cond = (rs1_val == rs2_val);
            NE:      cond = (rs1_val != rs2_val);
            LT:      cond = ($signed(rs1_val) < $signed(rs2_val));
            GE:      cond = ($signed(rs1_val) >= $signed(rs2_val));
            LTU:     cond = (rs1_val < rs2_val);
            GEU:     cond = (rs1_val >= rs2_val);
            ALWAYS:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge CLK100MHZ) begin
        if (state == EXECUTE) begin
            result  <= dec.is_link ? pc + 32'd4 : alu_out;
            address <= dec.is_jalr ? {target[31:1], 1'b0} : target;
        end
    end

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            taken <= 1'b0;
        end else if (state == EXECUTE) begin
            taken <= cond;
        end
    end

    // Once evaluated, a non-branch never redirects the PC
    assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        (state inside {MEM_ACCESS, WRITE_BACK}) && dec.branch_op == NONE |-> !taken);

endmodule

// File: source/mmio.sv
`timescale 1ns/1ns

module mmio import cpu_pkg::*; (
    input  logic           CLK100MHZ,
    input  logic           rst_n,
    input  cpu_state_t     state,
    input  decoded_instr_t dec,
    input  logic [31:0]    pc,
    input  logic [31:0]    address,
    input  logic [31:0]    rs2_val,
    output logic [31:0]    instr,
    output logic [31:0]    load_data,
    input  logic [3:0]     sw,
    output logic [3:0]     led
);

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];

    logic [31:0] pc_off;
    logic [31:0] ram_off;
    logic        ram_sel;
    logic        led_sel;
    logic        sw_sel;
    logic [3:0]  wmask;
    logic [31:0] wdata;
    logic [31:0] raw;
    logic [31:0] lane;

    initial begin
        $readmemh("source/program.hex", rom);
    end

    assign pc_off = pc - ROM_BASE;
    assign instr  = rom[pc_off[$clog2(ROM_WORDS)+1:2]];

    // Address decode
    assign ram_off = address - RAM_BASE;
    assign ram_sel = (address >= RAM_BASE) && (ram_off < RAM_WORDS * 4);
    assign led_sel = (address == LED_ADDR);
    assign sw_sel  = (address == SW_ADDR);

    always_comb begin
        case (dec.mem_size)
            BYTE:    wmask = 4'b0001 << address[1:0];
            HALF:    wmask = 4'b0011 << address[1:0];
            default: wmask = 4'b1111;
        endcase
        wdata = rs2_val << {address[1:0], 3'b000};
    end

    always_ff @(posedge CLK100MHZ) begin
        if (state == MEM_ACCESS && dec.is_store && ram_sel) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    ram[ram_off[$clog2(RAM_WORDS)+1:2]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            led <= 4'b0;
        end else if (state == MEM_ACCESS && dec.is_store && led_sel) begin
            led <= rs2_val[3:0];
        end
    end

    // Pick the load word, shift the lane down and extend
    always_comb begin
        if (ram_sel) begin
            raw = ram[ram_off[$clog2(RAM_WORDS)+1:2]];
        end else if (sw_sel) begin
            raw = {28'b0, sw};
        end else begin
            raw = '0;
        end
        lane = raw >> {address[1:0], 3'b000};
    end

    always_ff @(posedge CLK100MHZ) begin
        if (state == MEM_ACCESS && dec.is_load) begin
            case (dec.mem_size)
                BYTE:    load_data <= dec.mem_unsigned ? {24'b0, lane[7:0]}
                                                       : {{24{lane[7]}}, lane[7:0]};
                HALF:    load_data <= dec.mem_unsigned ? {16'b0, lane[15:0]}
                                                       : {{16{lane[15]}}, lane[15:0]};
                default: load_data <= lane;
            endcase
        end
    end

    // Address from the ALU and size from the decoder
    assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        state == MEM_ACCESS && (dec.is_load || dec.is_store) && dec.mem_size == WORD
        |-> address[1:0] == 2'b00);

endmodule

// File: source/cpu.sv
`timescale 1ns/1ns

module cpu import cpu_pkg::*; (
    input  logic       CLK100MHZ,
    input  logic       rst_n,
    input  logic [3:0] sw,
    output logic [3:0] led
);

    cpu_state_t     state;
    logic [31:0]    pc;
    logic [31:0]    instr;
    decoded_instr_t dec;
    logic [31:0]    rs1_val;
    logic [31:0]    rs2_val;
    logic [31:0]    result;
    logic [31:0]    address;
    logic           taken;
    logic [31:0]    load_data;

    // Five-state sequence with one instruction per pass
    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_DECODE;
        end else begin
            case (state)
                FETCH_DECODE: state <= REG_READ;
                REG_READ:     state <= EXECUTE;
                EXECUTE:      state <= MEM_ACCESS;
                MEM_ACCESS:   state <= WRITE_BACK;
                default:      state <= FETCH_DECODE;
            endcase
        end
    end

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (state == WRITE_BACK) begin
            pc <= taken ? address : pc + 32'd4;
        end
    end

    decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    rf u_rf (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .state     (state),
        .dec       (dec),
        .result    (result),
        .load_data (load_data),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val)
    );

    alu u_alu (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .state     (state),
        .dec       (dec),
        .pc        (pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .result    (result),
        .address   (address),
        .taken     (taken)
    );

    mmio u_mmio (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .state     (state),
        .dec       (dec),
        .pc        (pc),
        .address   (address),
        .rs2_val   (rs2_val),
        .instr     (instr),
        .load_data (load_data),
        .sw        (sw),
        .led       (led)
    );

    assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        state inside {FETCH_DECODE, REG_READ, EXECUTE, MEM_ACCESS, WRITE_BACK});

    // Jump targets from the ALU must keep the PC on a word boundary
    assert property (@(posedge CLK100MHZ) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: test/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    localparam int SETTLE_CYCLES = 900;
    localparam int STORE_LIMIT   = 400;
    localparam int RANDOM_RUNS   = 25;

    logic       CLK100MHZ;
    logic       rst_n;
    logic [3:0] sw;
    logic [3:0] led;

    integer seed;
    int     errors;

    cpu DUT (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .sw        (sw),
        .led       (led)
    );

    initial begin
        CLK100MHZ = 1'b0;
        forever begin
            #5 CLK100MHZ = ~CLK100MHZ;
        end
    end

    // Low nibble of the sum 1..s xor s*4
    function automatic logic [3:0] expected_led(input logic [3:0] s);
        int sv;
        int sum;
        int mixed;
        sv    = s;
        sum   = sv * (sv + 1) / 2;
        mixed = sum ^ (sv * 4);
        return mixed[3:0];
    endfunction

    task automatic check_led(input logic [3:0] expected, input logic [3:0] actual,
                             input logic [3:0] s);
        if (actual !== expected) begin
            errors++;
            $display("ERR led: expected 0x%h, actual 0x%h (sw 0x%h)", expected, actual, s);
        end
    endtask

    task automatic hold_reset();
        for (int i = 0; i < 2; i++) begin
            @(posedge CLK100MHZ);
        end
        @(negedge CLK100MHZ);
        rst_n = 1'b1;
    endtask

    task automatic count_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK100MHZ);
        end
    endtask

    // LED must hold its value until the program reaches its SB
    task automatic watch_until_led_store(input logic [3:0] held, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < STORE_LIMIT && !seen; i++) begin
            @(negedge CLK100MHZ);
            check_led(held, led, sw);
            if (DUT.state == MEM_ACCESS && DUT.dec.is_store && DUT.address == LED_ADDR) begin
                seen = 1'b1;
            end
        end
    endtask

    // Long enough for an old pass to finish and a full new pass to run
    task automatic run_switch_case(input logic [3:0] s, input logic [3:0] expected);
        @(negedge CLK100MHZ);
        sw = s;
        count_cycles(SETTLE_CYCLES);
        check_led(expected, led, s);
    endtask

    initial begin
        integer     r;
        logic [3:0] v;
        logic       store_seen;

        seed   = 57834;
        errors = 0;
        rst_n  = 1'b0;
        sw     = 4'h0;

        hold_reset();
        watch_until_led_store(4'h0, store_seen);

        if (!store_seen) begin
            errors++;
            $display("timeout: no store to the LED register after reset");
        end else begin
            // Longest loop gives 120 xor 60
            run_switch_case(4'hF, 4'h4);

            // Loop body skipped and led falls back to 0
            run_switch_case(4'h0, 4'h0);

            for (int i = 0; i < RANDOM_RUNS; i++) begin
                r = $random(seed);
                v = r[3:0];
                run_switch_case(v, expected_led(v));
            end

            // Same value twice while the program keeps looping
            r = $random(seed);
            v = r[3:0];
            run_switch_case(v, expected_led(v));
            watch_until_led_store(expected_led(v), store_seen);
            if (!store_seen) begin
                errors++;
                $display("timeout: program stopped storing to the LED register");
            end
            run_switch_case(v, expected_led(v));
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: source/program.hex
// One RV32I instruction word per line in hex, from ROM address 0 upward
// Assembly for each word follows it
00002237  // 00: lui  x4, 0x2         I/O base 0x2000
00422083  // 04: lw   x1, 4(x4)       switches
00000113  // 08: addi x2, x0, 0
00000193  // 0c: addi x3, x0, 0
00118863  // 10: beq  x3, x1, 0x20
00118193  // 14: addi x3, x3, 1
00310133  // 18: add  x2, x2, x3
ff5ff06f  // 1c: jal  x0, 0x10
000012b7  // 20: lui  x5, 0x1         RAM base 0x1000
0022a023  // 24: sw   x2, 0(x5)
0002c303  // 28: lbu  x6, 0(x5)
00209393  // 2c: slli x7, x1, 2
00734333  // 30: xor  x6, x6, x7
00620023  // 34: sb   x6, 0(x4)       LED register
fc9ff06f  // 38: jal  x0, 0x00

// File: list.f
source/cpu_pkg.sv
source/decode.sv
source/rf.sv
source/alu.sv
source/mmio.sv
source/cpu.sv
test/tb_cpu.sv

// File: Bender.yml
package:
  name: rv32i_multicycle

sources:
  - source/cpu_pkg.sv
  - source/decode.sv
  - source/rf.sv
  - source/alu.sv
  - source/mmio.sv
  - source/cpu.sv
  - target: test
    files:
      - test/tb_cpu.sv
